//--- proc_pkg.sv
package proc_pkg;

  // instruction word layout
  localparam int IW  = 17;
  localparam int OPW = 5;
  // operand doubles as pc / memory address width
  localparam int AW  = IW - OPW;

  // opcode encodings
  typedef enum logic [OPW-1:0] {
    OP_NOP  = 5'd0,
    OP_LDI  = 5'd1,
    OP_LDM  = 5'd2,
    OP_STM  = 5'd3,
    OP_MOVR = 5'd4,
    OP_MVAC = 5'd5,
    OP_ADD  = 5'd6,
    OP_SUB  = 5'd7,
    OP_AND  = 5'd8,
    OP_OR   = 5'd9,
    OP_INC  = 5'd10,
    OP_CLR  = 5'd11,
    OP_JMP  = 5'd12,
    OP_JZ   = 5'd13,
    OP_END  = 5'd14
  } opcode_e;

  // opcode in the top bits, operand below
  typedef struct packed {
    opcode_e         opcode;
    logic [AW-1:0]   operand;
  } instr_t;

  // general register select, from operand[2:0]
  typedef enum logic [2:0] {
    SEL_R  = 3'd0,
    SEL_R1 = 3'd1,
    SEL_R2 = 3'd2,
    SEL_R3 = 3'd3,
    SEL_R4 = 3'd4
  } reg_sel_e;

  typedef enum logic [2:0] {
    ALU_PASS = 3'd0,
    ALU_ADD  = 3'd1,
    ALU_SUB  = 3'd2,
    ALU_AND  = 3'd3,
    ALU_OR   = 3'd4,
    ALU_INC  = 3'd5
  } alu_op_e;

  typedef enum logic [2:0] {
    BUS_REG  = 3'd0,
    BUS_AC   = 3'd1,
    BUS_ALU  = 3'd2,
    BUS_DMEM = 3'd3,
    BUS_IMM  = 3'd4,
    BUS_PC   = 3'd5
  } bus_src_e;

  // one control word per cycle, read by every datapath block
  typedef struct packed {
    alu_op_e  alu_op;
    bus_src_e bus_src;
    reg_sel_e reg_sel;
    logic     ac_we;
    logic     reg_we;
    logic     pc_we;
    logic     pc_inc;
    logic     ir_we;
    logic     ac_clr;
  } ctrl_t;

  // idle word: alu passes ac, nothing written
  localparam ctrl_t CTRL_IDLE = '{
    alu_op:  ALU_PASS,
    bus_src: BUS_AC,
    reg_sel: SEL_R,
    default: 1'b0
  };

endpackage

//--- reg_bank.sv
`timescale 1ns/1ps

module reg_bank #(
  parameter int DW = 12
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  proc_pkg::ctrl_t          ctrl,
  input  logic [DW-1:0]            bus,
  input  logic [DW-1:0]            ac_next,
  input  proc_pkg::instr_t         im_data,
  output logic [DW-1:0]            ac,
  output logic [DW-1:0]            sel_reg,
  output logic [proc_pkg::AW-1:0]  pc,
  output proc_pkg::instr_t         ir
);

  // general registers
  logic [DW-1:0] r_q;
  logic [DW-1:0] r1_q;
  logic [DW-1:0] r2_q;
  logic [DW-1:0] r3_q;
  logic [DW-1:0] r4_q;
  // held instruction, valid from the end of exec
  proc_pkg::instr_t ir_q;

  // accumulator, clear wins over load
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ac <= '0;
    end else if (ctrl.ac_clr) begin
      ac <= '0;
    end else if (ctrl.ac_we) begin
      ac <= ac_next;
    end
  end

  // register file written from the bus
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_q  <= '0;
      r1_q <= '0;
      r2_q <= '0;
      r3_q <= '0;
      r4_q <= '0;
    end else if (ctrl.reg_we) begin
      case (ctrl.reg_sel)
        proc_pkg::SEL_R:  r_q  <= bus;
        proc_pkg::SEL_R1: r1_q <= bus;
        proc_pkg::SEL_R2: r2_q <= bus;
        proc_pkg::SEL_R3: r3_q <= bus;
        proc_pkg::SEL_R4: r4_q <= bus;
        // selects 5..7 write nothing
        default: ;
      endcase
    end
  end

  // pc: jump target comes over the bus low bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (ctrl.pc_we) begin
      pc <= bus[proc_pkg::AW-1:0];
    end else if (ctrl.pc_inc) begin
      pc <= pc + proc_pkg::AW'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.ir_we) begin
      ir_q <= im_data;
    end
  end

  // fetched word passed straight through during exec so decode is same-cycle
  assign ir = ctrl.ir_we ? im_data : ir_q;

  // read port for alu operand b and the bus
  always_comb begin
    case (ctrl.reg_sel)
      proc_pkg::SEL_R1: sel_reg = r1_q;
      proc_pkg::SEL_R2: sel_reg = r2_q;
      proc_pkg::SEL_R3: sel_reg = r3_q;
      proc_pkg::SEL_R4: sel_reg = r4_q;
      default:          sel_reg = r_q;
    endcase
  end

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu #(
  parameter int DW = 12
) (
  // a is ac, b is the selected register
  input  logic [DW-1:0]     a,
  input  logic [DW-1:0]     b,
  input  proc_pkg::alu_op_e op,
  output logic [DW-1:0]     result,
  output logic              zero
);

  // all ops wrap modulo 2^DW
  always_comb begin
    case (op)
      proc_pkg::ALU_ADD: begin
        result = a + b;
      end
      proc_pkg::ALU_SUB: begin
        // two's complement, borrow dropped
        result = a - b;
      end
      proc_pkg::ALU_AND: begin
        result = a & b;
      end
      proc_pkg::ALU_OR: begin
        result = a | b;
      end
      proc_pkg::ALU_INC: begin
        result = a + DW'(1);
      end
      default: begin
        // pass mode, used for the jz test on ac
        result = a;
      end
    endcase
  end

  assign zero = (result == '0);

endmodule

//--- bus_writeback.sv
`timescale 1ns/1ps

module bus_writeback #(
  parameter int DW = 12
) (
  input  proc_pkg::ctrl_t          ctrl,
  input  logic [DW-1:0]            sel_reg,
  input  logic [DW-1:0]            ac,
  input  logic [DW-1:0]            alu_result,
  input  logic [DW-1:0]            dm_rdata,
  input  proc_pkg::instr_t         ir,
  input  logic [proc_pkg::AW-1:0]  pc,
  output logic [DW-1:0]            bus,
  output logic [DW-1:0]            ac_next
);

  // shared bus source select
  always_comb begin
    case (ctrl.bus_src)
      proc_pkg::BUS_REG:  bus = sel_reg;
      proc_pkg::BUS_AC:   bus = ac;
      proc_pkg::BUS_ALU:  bus = alu_result;
      proc_pkg::BUS_DMEM: bus = dm_rdata;
      // operand zero-extended, also the jump target
      proc_pkg::BUS_IMM:  bus = DW'(ir.operand);
      proc_pkg::BUS_PC:   bus = DW'(pc);
      default:            bus = ac;
    endcase
  end

  // arithmetic results go to ac direct, loads and moves via the bus
  always_comb begin
    if (ctrl.alu_op != proc_pkg::ALU_PASS) begin
      ac_next = alu_result;
    end else begin
      ac_next = bus;
    end
  end

endmodule

//--- control_unit.sv
`timescale 1ns/1ps

module control_unit (
  input  logic              clk,
  input  logic              rst_n,
  input  proc_pkg::instr_t  ir,
  input  logic              ac_zero,
  output proc_pkg::ctrl_t   ctrl,
  output logic              dm_we,
  output logic              halted
);

  typedef enum logic [1:0] {
    S_FETCH = 2'd0,
    S_EXEC  = 2'd1,
    S_MEM   = 2'd2,
    S_HALT  = 2'd3
  } state_e;

  state_e state;
  state_e state_next;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_FETCH;
    end else begin
      state <= state_next;
    end
  end

  // decode and next state
  always_comb begin
    ctrl       = proc_pkg::CTRL_IDLE;
    state_next = state;
    dm_we      = 1'b0;
    case (state)
      S_FETCH: begin
        // pc is on im_addr, word returns next cycle
        state_next = S_EXEC;
      end
      S_EXEC: begin
        ctrl.ir_we   = 1'b1;
        // every exec steps pc unless a jump is taken
        ctrl.pc_inc  = 1'b1;
        ctrl.reg_sel = proc_pkg::reg_sel_e'(ir.operand[2:0]);
        state_next   = S_FETCH;
        case (ir.opcode)
          proc_pkg::OP_LDI: begin
            ctrl.bus_src = proc_pkg::BUS_IMM;
            ctrl.ac_we   = 1'b1;
          end
          proc_pkg::OP_LDM: begin
            // dm_addr is up now, data lands in mem
            state_next = S_MEM;
          end
          proc_pkg::OP_STM: begin
            ctrl.bus_src = proc_pkg::BUS_AC;
            dm_we        = 1'b1;
          end
          proc_pkg::OP_MOVR: begin
            ctrl.bus_src = proc_pkg::BUS_AC;
            ctrl.reg_we  = 1'b1;
          end
          proc_pkg::OP_MVAC: begin
            ctrl.bus_src = proc_pkg::BUS_REG;
            ctrl.ac_we   = 1'b1;
          end
          proc_pkg::OP_ADD: begin
            ctrl.alu_op  = proc_pkg::ALU_ADD;
            ctrl.bus_src = proc_pkg::BUS_ALU;
            ctrl.ac_we   = 1'b1;
          end
          proc_pkg::OP_SUB: begin
            ctrl.alu_op  = proc_pkg::ALU_SUB;
            ctrl.bus_src = proc_pkg::BUS_ALU;
            ctrl.ac_we   = 1'b1;
          end
          proc_pkg::OP_AND: begin
            ctrl.alu_op  = proc_pkg::ALU_AND;
            ctrl.bus_src = proc_pkg::BUS_ALU;
            ctrl.ac_we   = 1'b1;
          end
          proc_pkg::OP_OR: begin
            ctrl.alu_op  = proc_pkg::ALU_OR;
            ctrl.bus_src = proc_pkg::BUS_ALU;
            ctrl.ac_we   = 1'b1;
          end
          proc_pkg::OP_INC: begin
            ctrl.alu_op  = proc_pkg::ALU_INC;
            ctrl.bus_src = proc_pkg::BUS_ALU;
            ctrl.ac_we   = 1'b1;
          end
          proc_pkg::OP_CLR: begin
            ctrl.ac_clr = 1'b1;
          end
          proc_pkg::OP_JMP: begin
            ctrl.bus_src = proc_pkg::BUS_IMM;
            ctrl.pc_inc  = 1'b0;
            ctrl.pc_we   = 1'b1;
          end
          proc_pkg::OP_JZ: begin
            // alu stays in pass, so ac_zero reflects ac
            ctrl.bus_src = proc_pkg::BUS_IMM;
            if (ac_zero) begin
              ctrl.pc_inc = 1'b0;
              ctrl.pc_we  = 1'b1;
            end
          end
          proc_pkg::OP_END: begin
            // pc still steps past end, then freezes
            state_next = S_HALT;
          end
          // nop and undefined opcodes
          default: ;
        endcase
      end
      S_MEM: begin
        // ir still holds the ldm, dm_rdata valid now
        ctrl.bus_src = proc_pkg::BUS_DMEM;
        ctrl.ac_we   = 1'b1;
        state_next   = S_FETCH;
      end
      default: begin
        // halt until reset
        state_next = S_HALT;
      end
    endcase
  end

  assign halted = (state == S_HALT);

endmodule

//--- proc_top.sv
`timescale 1ns/1ps

module proc_top #(
  parameter int DW = 12
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  proc_pkg::instr_t         im_data,
  input  logic [DW-1:0]            dm_rdata,
  output logic [proc_pkg::AW-1:0]  im_addr,
  output logic [proc_pkg::AW-1:0]  dm_addr,
  output logic [DW-1:0]            dm_wdata,
  output logic                     dm_we,
  output logic                     halted,
  output logic [proc_pkg::AW-1:0]  pc_out
);

  proc_pkg::ctrl_t          ctrl;
  proc_pkg::instr_t         ir;
  logic [DW-1:0]            ac;
  logic [DW-1:0]            sel_reg;
  logic [proc_pkg::AW-1:0]  pc;
  logic [DW-1:0]            alu_result;
  logic                     alu_zero;
  logic [DW-1:0]            bus;
  logic [DW-1:0]            ac_next;

  reg_bank #(.DW(DW)) reg_bank_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctrl    (ctrl),
    .bus     (bus),
    .ac_next (ac_next),
    .im_data (im_data),
    .ac      (ac),
    .sel_reg (sel_reg),
    .pc      (pc),
    .ir      (ir)
  );

  alu #(.DW(DW)) alu_inst (
    .a      (ac),
    .b      (sel_reg),
    .op     (ctrl.alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  bus_writeback #(.DW(DW)) bus_writeback_inst (
    .ctrl       (ctrl),
    .sel_reg    (sel_reg),
    .ac         (ac),
    .alu_result (alu_result),
    .dm_rdata   (dm_rdata),
    .ir         (ir),
    .pc         (pc),
    .bus        (bus),
    .ac_next    (ac_next)
  );

  control_unit control_unit_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .ir      (ir),
    .ac_zero (alu_zero),
    .ctrl    (ctrl),
    .dm_we   (dm_we),
    .halted  (halted)
  );

  // memory side: fetch from pc, data address from the operand
  assign im_addr  = pc;
  assign dm_addr  = ir.operand;
  assign dm_wdata = ac;
  assign pc_out   = pc;

endmodule

//--- proc_asserts.sv
`timescale 1ns/1ps

module proc_asserts (
  input logic            clk,
  input logic            rst_n,
  input proc_pkg::ctrl_t ctrl,
  input logic            dm_we,
  input logic            halted
);

  // failures so far, summed into the closing error count
  int fail_count = 0;

  // store strobe is a single exec cycle
  dm_we_pulse: assert property (@(posedge clk) disable iff (!rst_n) dm_we |=> !dm_we)
    else begin
      $error("dm_we high for more than one cycle");
      fail_count++;
    end

  // only reset leaves halt
  halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
    else begin
      $error("halted fell without reset");
      fail_count++;
    end

  // jump load and increment are exclusive
  pc_one_source: assert property (@(posedge clk) disable iff (!rst_n)
                                  !(ctrl.pc_we && ctrl.pc_inc))
    else begin
      $error("pc_we and pc_inc set together");
      fail_count++;
    end

  halt_no_store: assert property (@(posedge clk) disable iff (!rst_n) halted |-> !dm_we)
    else begin
      $error("dm_we raised while halted");
      fail_count++;
    end

endmodule

bind control_unit proc_asserts proc_asserts_inst (
  .clk    (clk),
  .rst_n  (rst_n),
  .ctrl   (ctrl),
  .dm_we  (dm_we),
  .halted (halted)
);

//--- tb_proc.sv
`timescale 1ns/1ps

module tb_proc;

  localparam int DW    = 12;
  localparam int AW    = proc_pkg::AW;
  localparam int DEPTH = 1 << AW;
  localparam int NPROG = 3;

  logic             clk;
  logic             rst_n;
  proc_pkg::instr_t im_data;
  logic [DW-1:0]    dm_rdata;
  logic [AW-1:0]    im_addr;
  logic [AW-1:0]    dm_addr;
  logic [DW-1:0]    dm_wdata;
  logic             dm_we;
  logic             halted;
  logic [AW-1:0]    pc_out;

  // instruction memory, data memory and its reset image
  proc_pkg::instr_t imem [DEPTH];
  logic [DW-1:0]    dmem [DEPTH];
  logic [DW-1:0]    dm_image [DEPTH];
  // data memory as the reference leaves it
  logic [DW-1:0]    exp_dmem [DEPTH];

  logic [AW-1:0] exp_pc;
  int            exp_cycles;
  int            run_cycles;
  int            busy_cycles;
  int            cycle_limit;
  int            seed;
  int            load_ptr;
  logic          prog_checked;
  int            err_word = 0;
  int            err_addr = 0;
  int            err_count = 0;
  int            err_flag = 0;

  proc_top #(.DW(DW)) proc_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .im_data  (im_data),
    .dm_rdata (dm_rdata),
    .im_addr  (im_addr),
    .dm_addr  (dm_addr),
    .dm_wdata (dm_wdata),
    .dm_we    (dm_we),
    .halted   (halted),
    .pc_out   (pc_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // both memories answer one cycle after the address
  // dmem goes back to its preset image while in reset
  always @(posedge clk) begin
    im_data  <= imem[im_addr];
    dm_rdata <= dmem[dm_addr];
    if (!rst_n) begin
      dmem <= dm_image;
    end else if (dm_we) begin
      dmem[dm_addr] <= dm_wdata;
    end
  end

  // cycles since reset release, frozen once halted
  always @(posedge clk) begin
    if (!rst_n) begin
      run_cycles <= 0;
    end else if (!halted) begin
      run_cycles <= run_cycles + 1;
    end
  end

  task automatic check_word(input string name, input logic [DW-1:0] got,
                            input logic [DW-1:0] exp);
    if (got !== exp) begin
      err_word++;
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input logic [AW-1:0] got,
                            input logic [AW-1:0] exp);
    if (got !== exp) begin
      err_addr++;
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_flag++;
      $display("ERR %0t %s got %0b expected %0b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      err_count++;
      $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic emit(input proc_pkg::opcode_e op, input int opd);
    imem[load_ptr] = '{opcode: op, operand: AW'(opd)};
    load_ptr++;
  endtask

  task automatic load_program(input int n);
    // unused words are nop, operand tagged with their own address
    for (int a = 0; a < DEPTH; a++) begin
      imem[a] = '{opcode: proc_pkg::OP_NOP, operand: AW'(a)};
    end
    load_ptr = 0;
    case (n)
      0: begin
        // arithmetic, 955 + 7f0 wraps past 12 bits
        emit(proc_pkg::OP_LDI, 'h7f0);
        emit(proc_pkg::OP_MOVR, 1);
        emit(proc_pkg::OP_LDI, 'h955);
        emit(proc_pkg::OP_ADD, 1);
        emit(proc_pkg::OP_STM, 'h100);
        emit(proc_pkg::OP_MOVR, 2);
        emit(proc_pkg::OP_LDI, 'h123);
        emit(proc_pkg::OP_SUB, 2);
        emit(proc_pkg::OP_STM, 'h101);
        emit(proc_pkg::OP_AND, 1);
        emit(proc_pkg::OP_OR, 2);
        emit(proc_pkg::OP_STM, 'h102);
        emit(proc_pkg::OP_LDI, 'hfff);
        emit(proc_pkg::OP_INC, 0);
        emit(proc_pkg::OP_STM, 'h103);
        emit(proc_pkg::OP_CLR, 0);
        emit(proc_pkg::OP_STM, 'h104);
        emit(proc_pkg::OP_END, 0);
      end
      1: begin
        // random preset words into r1..r4, read back by mvac
        emit(proc_pkg::OP_LDM, 'h010);
        emit(proc_pkg::OP_MOVR, 1);
        emit(proc_pkg::OP_LDM, 'h011);
        emit(proc_pkg::OP_MOVR, 2);
        emit(proc_pkg::OP_LDM, 'h012);
        emit(proc_pkg::OP_MOVR, 3);
        emit(proc_pkg::OP_LDM, 'h013);
        emit(proc_pkg::OP_MOVR, 4);
        emit(proc_pkg::OP_CLR, 0);
        emit(proc_pkg::OP_MVAC, 1);
        emit(proc_pkg::OP_ADD, 2);
        emit(proc_pkg::OP_STM, 'h200);
        emit(proc_pkg::OP_MVAC, 4);
        emit(proc_pkg::OP_SUB, 3);
        emit(proc_pkg::OP_STM, 'h201);
        emit(proc_pkg::OP_MVAC, 3);
        emit(proc_pkg::OP_STM, 'h202);
        emit(proc_pkg::OP_END, 0);
      end
      default: begin
        // countdown from 4 in ac, then jmp over two stores
        emit(proc_pkg::OP_LDI, 1);
        emit(proc_pkg::OP_MOVR, 2);
        emit(proc_pkg::OP_LDI, 4);
        emit(proc_pkg::OP_SUB, 2);
        emit(proc_pkg::OP_JZ, 6);
        emit(proc_pkg::OP_JMP, 3);
        emit(proc_pkg::OP_STM, 'h300);
        emit(proc_pkg::OP_JMP, 10);
        emit(proc_pkg::OP_STM, 'h301);
        emit(proc_pkg::OP_STM, 'h302);
        emit(proc_pkg::OP_INC, 0);
        // ac is 1 here, so no branch
        emit(proc_pkg::OP_JZ, 13);
        emit(proc_pkg::OP_STM, 'h303);
        emit(proc_pkg::OP_END, 0);
      end
    endcase
  endtask

  // instruction set interpreter over imem and a copy of the data image
  // 2 cycles per instruction, one more for ldm, end stops after stepping pc
  function automatic int interpret(output logic [AW-1:0] pc_end);
    proc_pkg::instr_t ins;
    logic [DW-1:0]    acc;
    logic [DW-1:0]    regs [5];
    logic [AW-1:0]    pc;
    logic [AW-1:0]    opd;
    int               sel;
    int               cycles;
    bit               done;
    acc    = '0;
    pc     = '0;
    cycles = 0;
    done   = 1'b0;
    for (int i = 0; i < 5; i++) begin
      regs[i] = '0;
    end
    for (int a = 0; a < DEPTH; a++) begin
      exp_dmem[a] = dm_image[a];
    end
    while (!done && cycles < 100000) begin
      ins    = imem[pc];
      opd    = ins.operand;
      sel    = (int'(opd[2:0]) > 4) ? 0 : int'(opd[2:0]);
      cycles += 2;
      pc_end = pc + AW'(1);
      case (ins.opcode)
        proc_pkg::OP_LDI:  acc = DW'(opd);
        proc_pkg::OP_LDM: begin
          acc = exp_dmem[opd];
          cycles += 1;
        end
        proc_pkg::OP_STM:  exp_dmem[opd] = acc;
        proc_pkg::OP_MOVR: regs[sel] = acc;
        proc_pkg::OP_MVAC: acc = regs[sel];
        proc_pkg::OP_ADD:  acc = acc + regs[sel];
        proc_pkg::OP_SUB:  acc = acc - regs[sel];
        proc_pkg::OP_AND:  acc = acc & regs[sel];
        proc_pkg::OP_OR:   acc = acc | regs[sel];
        proc_pkg::OP_INC:  acc = acc + DW'(1);
        proc_pkg::OP_CLR:  acc = '0;
        proc_pkg::OP_JMP:  pc_end = opd;
        proc_pkg::OP_JZ: begin
          if (acc == '0) begin
            pc_end = opd;
          end
        end
        proc_pkg::OP_END:  done = 1'b1;
        default: ;
      endcase
      pc = pc_end;
    end
    return cycles;
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_flag("halted", halted, 1'b0);
    check_flag("dm_we", dm_we, 1'b0);
    check_addr("pc_out", pc_out, '0);
    @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // checks each program once the core halts
  initial begin : compare_results
    forever begin
      @(posedge halted);
      @(negedge clk);
      check_addr("pc_out", pc_out, exp_pc);
      check_count("cycles to halt", run_cycles, exp_cycles);
      // halt window, nothing may move
      repeat (20) begin
        @(negedge clk);
        check_flag("halted", halted, 1'b1);
        check_flag("dm_we", dm_we, 1'b0);
        check_addr("pc_out", pc_out, exp_pc);
      end
      for (int a = 0; a < DEPTH; a++) begin
        check_word($sformatf("dmem[%0h]", a), dmem[a], exp_dmem[a]);
      end
      prog_checked = 1'b1;
    end
  end

  // only cycles where the core runs count toward the limit
  initial begin : watchdog
    busy_cycles = 0;
    while (busy_cycles <= cycle_limit) begin
      @(posedge clk);
      if (rst_n === 1'b1 && halted === 1'b0) begin
        busy_cycles++;
      end
    end
    $display("timeout: processor never halted within %0d cycles", cycle_limit);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : stimulus
    int total;
    int asrt;
    rst_n        <= 1'b0;
    im_data      <= '0;
    dm_rdata     <= '0;
    prog_checked = 1'b0;
    seed         = 86468;
    for (int a = 0; a < DEPTH; a++) begin
      dm_image[a] = DW'($random(seed));
    end
    total = 0;
    for (int n = 0; n < NPROG; n++) begin
      load_program(n);
      total += interpret(exp_pc);
    end
    cycle_limit = 2 * total + 100;
    for (int n = 0; n < NPROG; n++) begin
      load_program(n);
      exp_cycles = interpret(exp_pc);
      apply_reset();
      wait (prog_checked);
      prog_checked = 1'b0;
    end
    asrt = proc_top_inst.control_unit_inst.proc_asserts_inst.fail_count;
    $display("errors: word %0d addr %0d count %0d flag %0d assert %0d",
             err_word, err_addr, err_count, err_flag, asrt);
    if (err_word + err_addr + err_count + err_flag + asrt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- flist.f
proc_pkg.sv
reg_bank.sv
alu.sv
bus_writeback.sv
control_unit.sv
proc_top.sv
proc_asserts.sv
tb_proc.sv

//--- Makefile
SRCS := $(shell cat flist.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_proc: flist.f $(SRCS)
	verilator --binary --assert --top-module tb_proc -f flist.f

run: obj_dir/Vtb_proc
	@out="$$(obj_dir/Vtb_proc +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
